// ==== Bender.yml ====
package:
  name: rx_dcore

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rx_dcore_pkg.sv
      - rtl/dcore_cfg_if.sv
      - rtl/dcore_axil_regs.sv
      - rtl/bit_source.sv
      - rtl/lane_fifo.sv
      - rtl/prbs_checker.sv
      - rtl/rx_dcore.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/rx_dcore_assert.sv
      - verif/tb_rx_dcore.sv

// ==== rtl/bit_source.sv ====
`timescale 1ns/100ps
`include "rx_dcore_defs.svh"

module bit_source (
    input  logic                     clk_adc,
    input  logic                     cdr_rstb,
    input  rx_dcore_pkg::adc_code_t  adc_code_i [`NTI-1:0],
    input  logic                     adc_valid_i,
    dcore_cfg_if.src                 cfg_i,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output rx_dcore_pkg::lane_word_t out_word_o
);

    logic [`PRBS_N-1:0]       prbs_q;
    logic [`PRBS_N-1:0]       prbs_nxt;
    rx_dcore_pkg::lane_word_t prbs_bits;
    rx_dcore_pkg::lane_word_t sliced;
    logic                     inj_pend_q;
    logic                     bist;
    logic                     load;

    assign bist = (cfg_i.src_sel == rx_dcore_pkg::SRC_BIST);
    // output register free, or its word leaves this cycle
    assign load = !out_valid_o || out_ready_i;

    // sign slicer, non-negative code gives 1
    always_comb begin
        for (int k = 0; k < `NTI; k++) begin
            sliced[k] = ~adc_code_i[k][`NADC-1];
        end
    end

    // unrolled Fibonacci PRBS7, prbs_q[0] is the newest bit
    always_comb begin
        logic fb;
        prbs_nxt = prbs_q;
        for (int k = 0; k < `NTI; k++) begin
            fb           = prbs_nxt[`PRBS_TAP_A-1] ^ prbs_nxt[`PRBS_TAP_B-1];
            prbs_bits[k] = fb;
            prbs_nxt     = {prbs_nxt[`PRBS_N-2:0], fb};
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            out_valid_o <= 1'b0;
            prbs_q      <= '1;
            inj_pend_q  <= 1'b0;
        end else begin
            if (load) begin
                out_valid_o <= bist || adc_valid_i;
                if (bist) begin
                    prbs_q <= prbs_nxt;
                end
            end
            if (cfg_i.inj_pulse) begin
                inj_pend_q <= 1'b1;
            end else if (load && bist) begin
                inj_pend_q <= 1'b0;
            end
        end
    end

    // error injection flips only the emitted bit 0, not the generator
    always_ff @(posedge clk_adc) begin
        if (load) begin
            out_word_o <= bist ? (prbs_bits ^ rx_dcore_pkg::lane_word_t'(inj_pend_q)) : sliced;
        end
    end

endmodule

// ==== rtl/dcore_axil_regs.sv ====
`timescale 1ns/100ps
`include "rx_dcore_defs.svh"

module dcore_axil_regs (
    input  logic               clk_adc,
    input  logic               cdr_rstb,
    input  logic [`AXI_AW-1:0] s_awaddr_i,
    input  logic               s_awvalid_i,
    output logic               s_awready_o,
    input  logic [`AXI_DW-1:0] s_wdata_i,
    input  logic               s_wvalid_i,
    output logic               s_wready_o,
    output logic [1:0]         s_bresp_o,
    output logic               s_bvalid_o,
    input  logic               s_bready_i,
    input  logic [`AXI_AW-1:0] s_araddr_i,
    input  logic               s_arvalid_i,
    output logic               s_arready_o,
    output logic [`AXI_DW-1:0] s_rdata_o,
    output logic [1:0]         s_rresp_o,
    output logic               s_rvalid_o,
    input  logic               s_rready_i,
    dcore_cfg_if.regs          cfg_o
);

    rx_dcore_pkg::axi_wr_state_e wr_state_q;
    rx_dcore_pkg::axi_rd_state_e rd_state_q;
    rx_dcore_pkg::reg_addr_e     wr_addr;
    rx_dcore_pkg::reg_addr_e     rd_addr;
    logic [1:0]                  ctrl_q;
    logic                        clr_q;
    logic                        inj_q;
    logic [`AXI_DW-1:0]          rd_mux;
    logic [`AXI_DW-1:0]          rdata_q;
    logic                        wr_fire;
    logic                        rd_fire;

    assign wr_addr = rx_dcore_pkg::reg_addr_e'(s_awaddr_i);
    assign rd_addr = rx_dcore_pkg::reg_addr_e'(s_araddr_i);

    //////////////////////////////
    // write channel
    //////////////////////////////

    // address and data are taken together in one cycle
    assign wr_fire     = (wr_state_q == rx_dcore_pkg::WR_IDLE) && s_awvalid_i && s_wvalid_i;
    assign s_awready_o = wr_fire;
    assign s_wready_o  = wr_fire;
    assign s_bvalid_o  = (wr_state_q == rx_dcore_pkg::WR_RESP);
    assign s_bresp_o   = 2'b00;

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wr_state_q <= rx_dcore_pkg::WR_IDLE;
            ctrl_q     <= '0;
            clr_q      <= 1'b0;
            inj_q      <= 1'b0;
        end else begin
            // command bits are single-cycle strobes
            clr_q <= 1'b0;
            inj_q <= 1'b0;
            case (wr_state_q)
                rx_dcore_pkg::WR_IDLE: begin
                    if (wr_fire) begin
                        wr_state_q <= rx_dcore_pkg::WR_RESP;
                        case (wr_addr)
                            rx_dcore_pkg::REG_CTRL: ctrl_q <= s_wdata_i[1:0];
                            rx_dcore_pkg::REG_CMD: begin
                                clr_q <= s_wdata_i[0];
                                inj_q <= s_wdata_i[1];
                            end
                            default: ;
                        endcase
                    end
                end
                rx_dcore_pkg::WR_RESP: begin
                    if (s_bready_i) begin
                        wr_state_q <= rx_dcore_pkg::WR_IDLE;
                    end
                end
                default: wr_state_q <= rx_dcore_pkg::WR_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // read channel
    //////////////////////////////

    assign rd_fire     = (rd_state_q == rx_dcore_pkg::RD_IDLE) && s_arvalid_i;
    assign s_arready_o = rd_fire;
    assign s_rvalid_o  = (rd_state_q == rx_dcore_pkg::RD_DATA);
    assign s_rresp_o   = 2'b00;
    assign s_rdata_o   = rdata_q;

    always_comb begin
        case (rd_addr)
            rx_dcore_pkg::REG_CTRL:  rd_mux = {{(`AXI_DW-2){1'b0}}, ctrl_q};
            rx_dcore_pkg::REG_ERR:   rd_mux = `AXI_DW'(cfg_o.err_count);
            rx_dcore_pkg::REG_TOTAL: rd_mux = `AXI_DW'(cfg_o.total_count);
            // CMD is write only
            default:                 rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            rd_state_q <= rx_dcore_pkg::RD_IDLE;
        end else if (rd_fire) begin
            rd_state_q <= rx_dcore_pkg::RD_DATA;
        end else if (s_rvalid_o && s_rready_i) begin
            rd_state_q <= rx_dcore_pkg::RD_IDLE;
        end
    end

    // snapshot held until rready
    always_ff @(posedge clk_adc) begin
        if (rd_fire) begin
            rdata_q <= rd_mux;
        end
    end

    assign cfg_o.src_sel   = rx_dcore_pkg::bit_src_e'(ctrl_q[0]);
    assign cfg_o.chk_en    = ctrl_q[1];
    assign cfg_o.clr_pulse = clr_q;
    assign cfg_o.inj_pulse = inj_q;

endmodule

// ==== rtl/dcore_cfg_if.sv ====
`timescale 1ns/100ps
`include "rx_dcore_defs.svh"

interface dcore_cfg_if;

    // control from the register block
    rx_dcore_pkg::bit_src_e src_sel;
    logic                   chk_en;
    logic                   clr_pulse;
    logic                   inj_pulse;

    // status back from the checker
    logic [`CNT_W-1:0]      err_count;
    logic [`CNT_W-1:0]      total_count;

    modport regs (
        output src_sel,
        output chk_en,
        output clr_pulse,
        output inj_pulse,
        input  err_count,
        input  total_count
    );

    modport src (input src_sel, input inj_pulse);

    modport chk (input chk_en, input clr_pulse, output err_count, output total_count);

endinterface

// ==== rtl/lane_fifo.sv ====
`timescale 1ns/100ps
`include "rx_dcore_defs.svh"

module lane_fifo (
    input  logic                     clk_adc,
    input  logic                     cdr_rstb,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  rx_dcore_pkg::lane_word_t in_word_i,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output rx_dcore_pkg::lane_word_t out_word_o
);

    localparam int PTR_W = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
    localparam int LVL_W = $clog2(`FIFO_DEPTH + 1);

    rx_dcore_pkg::lane_word_t mem_q [`FIFO_DEPTH];
    logic [PTR_W-1:0]         wr_ptr_q;
    logic [PTR_W-1:0]         rd_ptr_q;
    logic [LVL_W-1:0]         level_q;
    logic                     push;
    logic                     pop;

    assign in_ready_o  = (level_q != LVL_W'(`FIFO_DEPTH));
    assign out_valid_o = (level_q != '0);
    assign out_word_o  = mem_q[rd_ptr_q];
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // level moves only when one side is active alone
            case ({push, pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    always_ff @(posedge clk_adc) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_word_i;
        end
    end

endmodule

// ==== rtl/prbs_checker.sv ====
`timescale 1ns/100ps
`include "rx_dcore_defs.svh"

module prbs_checker (
    input  logic                     clk_adc,
    input  logic                     cdr_rstb,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  rx_dcore_pkg::lane_word_t in_word_i,
    dcore_cfg_if.chk                 cfg_i
);

    localparam int FILL_W = $clog2(`PRBS_N + 1);
    localparam int ADD_W  = $clog2(`NTI + 1);

    logic [`PRBS_N-1:0] hist_q;
    logic [`PRBS_N-1:0] hist_nxt;
    logic [FILL_W-1:0]  fill_q;
    logic [FILL_W-1:0]  fill_nxt;
    logic [ADD_W-1:0]   err_add;
    logic [ADD_W-1:0]   tot_add;
    logic [`CNT_W-1:0]  err_q;
    logic [`CNT_W-1:0]  total_q;
    logic               take;

    // disabled checker back-pressures the FIFO
    assign in_ready_o = cfg_i.chk_en;
    assign take       = in_valid_i && in_ready_o;

    // self-synchronizing check, history holds received bits
    always_comb begin
        logic pred;
        hist_nxt = hist_q;
        fill_nxt = fill_q;
        err_add  = '0;
        tot_add  = '0;
        for (int k = 0; k < `NTI; k++) begin
            pred = hist_nxt[`PRBS_TAP_A-1] ^ hist_nxt[`PRBS_TAP_B-1];
            if (fill_nxt == FILL_W'(`PRBS_N)) begin
                tot_add = tot_add + 1'b1;
                if (in_word_i[k] != pred) begin
                    err_add = err_add + 1'b1;
                end
            end else begin
                fill_nxt = fill_nxt + 1'b1;
            end
            hist_nxt = {hist_nxt[`PRBS_N-2:0], in_word_i[k]};
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hist_q  <= '0;
            fill_q  <= '0;
            err_q   <= '0;
            total_q <= '0;
        end else begin
            if (take) begin
                hist_q <= hist_nxt;
            end
            // clear wins over a word taken in the same cycle
            if (cfg_i.clr_pulse) begin
                fill_q  <= '0;
                err_q   <= '0;
                total_q <= '0;
            end else if (take) begin
                fill_q  <= fill_nxt;
                err_q   <= err_q + `CNT_W'(err_add);
                total_q <= total_q + `CNT_W'(tot_add);
            end
        end
    end

    assign cfg_i.err_count   = err_q;
    assign cfg_i.total_count = total_q;

endmodule

// ==== rtl/rx_dcore.sv ====
`timescale 1ns/100ps
`include "rx_dcore_defs.svh"

module rx_dcore (
    input  logic                    clk_adc,
    input  logic                    cdr_rstb,
    input  rx_dcore_pkg::adc_code_t adc_code_i [`NTI-1:0],
    input  logic                    adc_valid_i,
    input  logic [`AXI_AW-1:0]      s_awaddr_i,
    input  logic                    s_awvalid_i,
    output logic                    s_awready_o,
    input  logic [`AXI_DW-1:0]      s_wdata_i,
    input  logic                    s_wvalid_i,
    output logic                    s_wready_o,
    output logic [1:0]              s_bresp_o,
    output logic                    s_bvalid_o,
    input  logic                    s_bready_i,
    input  logic [`AXI_AW-1:0]      s_araddr_i,
    input  logic                    s_arvalid_i,
    output logic                    s_arready_o,
    output logic [`AXI_DW-1:0]      s_rdata_o,
    output logic [1:0]              s_rresp_o,
    output logic                    s_rvalid_o,
    input  logic                    s_rready_i
);

    dcore_cfg_if u_cfg ();

    // source to FIFO
    logic                     src_valid;
    logic                     src_ready;
    rx_dcore_pkg::lane_word_t src_word;

    // FIFO to checker
    logic                     chk_valid;
    logic                     chk_ready;
    rx_dcore_pkg::lane_word_t chk_word;

    dcore_axil_regs u_regs (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .cfg_o       (u_cfg.regs)
    );

    bit_source u_src (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .adc_code_i  (adc_code_i),
        .adc_valid_i (adc_valid_i),
        .cfg_i       (u_cfg.src),
        .out_valid_o (src_valid),
        .out_ready_i (src_ready),
        .out_word_o  (src_word)
    );

    lane_fifo u_fifo (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .in_valid_i  (src_valid),
        .in_ready_o  (src_ready),
        .in_word_i   (src_word),
        .out_valid_o (chk_valid),
        .out_ready_i (chk_ready),
        .out_word_o  (chk_word)
    );

    prbs_checker u_chk (
        .clk_adc    (clk_adc),
        .cdr_rstb   (cdr_rstb),
        .in_valid_i (chk_valid),
        .in_ready_o (chk_ready),
        .in_word_i  (chk_word),
        .cfg_i      (u_cfg.chk)
    );

endmodule

// ==== rtl/rx_dcore_defs.svh ====
`ifndef RX_DCORE_DEFS_SVH
`define RX_DCORE_DEFS_SVH

//////////////////////////////
// datapath sizes
//////////////////////////////

// lanes per word, one bit each after slicing
`define NTI         4
// signed ADC code width
`define NADC        8
// lane FIFO entries
`define FIFO_DEPTH  4

//////////////////////////////
// PRBS7 polynomial
//////////////////////////////

`define PRBS_N      7
// taps counted in bits back from the newest
`define PRBS_TAP_A  7
`define PRBS_TAP_B  6

//////////////////////////////
// register bus
//////////////////////////////

`define AXI_AW      4
`define AXI_DW      32
`define CNT_W       32

`endif

// ==== rtl/rx_dcore_pkg.sv ====
`include "rx_dcore_defs.svh"

package rx_dcore_pkg;

    // bit 0 is the earliest bit in time
    typedef logic [`NTI-1:0] lane_word_t;

    typedef logic signed [`NADC-1:0] adc_code_t;

    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } bit_src_e;

    // byte addresses of the register map
    typedef enum logic [`AXI_AW-1:0] {
        REG_CTRL  = 4'h0,
        REG_CMD   = 4'h4,
        REG_ERR   = 4'h8,
        REG_TOTAL = 4'hC
    } reg_addr_e;

    typedef enum logic {WR_IDLE, WR_RESP} axi_wr_state_e;

    typedef enum logic {RD_IDLE, RD_DATA} axi_rd_state_e;

endpackage

// ==== sources.f ====
+incdir+rtl
rtl/rx_dcore_pkg.sv
rtl/dcore_cfg_if.sv
rtl/dcore_axil_regs.sv
rtl/bit_source.sv
rtl/lane_fifo.sv
rtl/prbs_checker.sv
rtl/rx_dcore.sv
verif/rx_dcore_assert.sv
verif/tb_rx_dcore.sv

// ==== verif/rx_dcore_assert.sv ====
`timescale 1ns/100ps
`include "rx_dcore_defs.svh"

module rx_dcore_assert (
    input logic                               clk_adc,
    input logic                               cdr_rstb,
    input logic                               s_bvalid_i,
    input logic                               s_bready_i,
    input logic                               s_rvalid_i,
    input logic                               s_rready_i,
    input logic [`AXI_DW-1:0]                 s_rdata_i,
    input logic [$clog2(`FIFO_DEPTH)-1:0]     fifo_wr_ptr_i,
    input logic [$clog2(`FIFO_DEPTH+1)-1:0]   fifo_level_i
);

    int fail_cnt = 0;

    // responses stay up until the master takes them
    bvalid_hold: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        s_bvalid_i && !s_bready_i |=> s_bvalid_i)
        else begin
            fail_cnt++;
            $error("bvalid dropped before bready");
        end

    rvalid_hold: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        s_rvalid_i && !s_rready_i |=> s_rvalid_i)
        else begin
            fail_cnt++;
            $error("rvalid dropped before rready");
        end

    rdata_stable: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        s_rvalid_i && !s_rready_i |=> $stable(s_rdata_i))
        else begin
            fail_cnt++;
            $error("rdata changed while rvalid was held");
        end

    fifo_level_max: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        fifo_level_i <= `FIFO_DEPTH)
        else begin
            fail_cnt++;
            $error("lane FIFO level above its depth");
        end

    // write pointer stays put on an edge where the FIFO is full
    fifo_no_push_full: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        fifo_level_i == `FIFO_DEPTH |=> $stable(fifo_wr_ptr_i))
        else begin
            fail_cnt++;
            $error("lane FIFO pushed while full");
        end

endmodule

bind rx_dcore rx_dcore_assert u_assert (
    .clk_adc       (clk_adc),
    .cdr_rstb      (cdr_rstb),
    .s_bvalid_i    (s_bvalid_o),
    .s_bready_i    (s_bready_i),
    .s_rvalid_i    (s_rvalid_o),
    .s_rready_i    (s_rready_i),
    .s_rdata_i     (s_rdata_o),
    .fifo_wr_ptr_i (u_fifo.wr_ptr_q),
    .fifo_level_i  (u_fifo.level_q)
);

// ==== verif/rx_dcore_input.txt ====
# one command per line, all numbers hex
# W addr data | R addr expect | N addr (non-zero) | S addr (same as last read)
# A count codes (lane 0 in low byte) | P words flip_bit (ffffffff none) | D cycles
R 0 0
R 8 0
R c 0
W 0 2
P 14 ffffffff
D 14
R 8 0
R c 49
W 4 1
P 14 25
D 14
R 8 3
R c 49
W 0 3
W 4 1
D 28
R 8 0
N c
W 4 2
D 28
R 8 3
W 0 1
D a
N c
D a
S c
W 4 1
R 8 0
R c 0
R 0 1
W 0 2
D a
W 4 1
A 2 40404040
D a
R 8 1
R c 1
R 0 2

// ==== verif/tb_rx_dcore.sv ====
`timescale 1ns/100ps
`include "rx_dcore_defs.svh"

module tb_rx_dcore;

    logic                    clk_adc = 1'b0;
    logic                    cdr_rstb;
    rx_dcore_pkg::adc_code_t adc_code_i [`NTI-1:0];
    logic                    adc_valid_i;
    logic [`AXI_AW-1:0]      s_awaddr_i;
    logic                    s_awvalid_i;
    logic                    s_awready_o;
    logic [`AXI_DW-1:0]      s_wdata_i;
    logic                    s_wvalid_i;
    logic                    s_wready_o;
    logic [1:0]              s_bresp_o;
    logic                    s_bvalid_o;
    logic                    s_bready_i;
    logic [`AXI_AW-1:0]      s_araddr_i;
    logic                    s_arvalid_i;
    logic                    s_arready_o;
    logic [`AXI_DW-1:0]      s_rdata_o;
    logic [1:0]              s_rresp_o;
    logic                    s_rvalid_o;
    logic                    s_rready_i;

    // parsed input file
    logic [7:0]              cmd_q [$];
    int                      a0_q [$];
    int                      a1_q [$];
    logic                    file_ok;

    int                      data_errs = 0;
    int                      resp_errs = 0;
    int                      cmd_errs = 0;
    int                      cycle_cnt = 0;
    int                      cycle_limit = 0;
    logic [15:0]             lfsr = 16'd10439;
    logic [`PRBS_N-1:0]      prbs_hist;

    rx_dcore u_dut (.*);

    always #2 clk_adc = ~clk_adc;

    always @(posedge clk_adc) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not end within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // galois lfsr, one step per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // reference PRBS7, newest bit in prbs_hist[0]
    function automatic logic prbs_step();
        logic b;
        b = prbs_hist[`PRBS_TAP_A-1] ^ prbs_hist[`PRBS_TAP_B-1];
        prbs_hist = {prbs_hist[`PRBS_N-2:0], b};
        return b;
    endfunction

    task automatic idle_gap();
        repeat (rand_bits(2)) @(posedge clk_adc);
    endtask

    task automatic drive_word(input logic [`NTI*`NADC-1:0] codes);
        logic sent;
        sent = 1'b0;
        while (!sent) begin
            @(posedge clk_adc);
            // roughly one cycle in four stays idle
            if (rand_bits(2) == 0) begin
                adc_valid_i <= 1'b0;
            end else begin
                for (int k = 0; k < `NTI; k++) begin
                    adc_code_i[k] <= codes[k*`NADC +: `NADC];
                end
                adc_valid_i <= 1'b1;
                sent = 1'b1;
            end
        end
    endtask

    task automatic end_words();
        @(posedge clk_adc);
        adc_valid_i <= 1'b0;
    endtask

    task automatic send_prbs(input int n_words, input int flip);
        logic [`NTI*`NADC-1:0] codes;
        logic                  b;
        prbs_hist = '1;
        for (int w = 0; w < n_words; w++) begin
            for (int k = 0; k < `NTI; k++) begin
                b = prbs_step();
                if (w * `NTI + k == flip) begin
                    b = ~b;
                end
                // +64 for a one, -64 for a zero
                codes[k*`NADC +: `NADC] = b ? 8'h40 : 8'hC0;
            end
            drive_word(codes);
        end
        end_words();
    endtask

    //////////////////////////////
    // AXI4-Lite master
    //////////////////////////////

    task automatic axi_write(input int addr, input int data);
        idle_gap();
        @(posedge clk_adc);
        s_awaddr_i  <= addr[`AXI_AW-1:0];
        s_wdata_i   <= data;
        s_awvalid_i <= 1'b1;
        s_wvalid_i  <= 1'b1;
        do begin
            @(posedge clk_adc);
        end while (!(s_awready_o && s_wready_o));
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        s_bready_i  <= 1'b1;
        do begin
            @(posedge clk_adc);
        end while (!s_bvalid_o);
        assert (s_bresp_o == 2'b00) else begin
            resp_errs++;
            $display("Error at %0t: s_bresp_o expected 0, got %0d", $time, s_bresp_o);
        end
        s_bready_i <= 1'b0;
    endtask

    task automatic axi_read(input int addr, output logic [`AXI_DW-1:0] data);
        idle_gap();
        @(posedge clk_adc);
        s_araddr_i  <= addr[`AXI_AW-1:0];
        s_arvalid_i <= 1'b1;
        do begin
            @(posedge clk_adc);
        end while (!s_arready_o);
        s_arvalid_i <= 1'b0;
        s_rready_i  <= 1'b1;
        do begin
            @(posedge clk_adc);
        end while (!s_rvalid_o);
        data = s_rdata_o;
        assert (s_rresp_o == 2'b00) else begin
            resp_errs++;
            $display("Error at %0t: s_rresp_o expected 0, got %0d", $time, s_rresp_o);
        end
        s_rready_i <= 1'b0;
    endtask

    //////////////////////////////
    // command file
    //////////////////////////////

    task automatic load_commands();
        int         fd;
        int         n;
        int         a0;
        int         a1;
        int         total;
        string      line;
        logic [7:0] c;
        total = 0;
        fd = $fopen("verif/rx_dcore_input.txt", "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    a0 = 0;
                    a1 = 0;
                    n = $sscanf(line, "%c %h %h", c, a0, a1);
                    if (n >= 2) begin
                        cmd_q.push_back(c);
                        a0_q.push_back(a0);
                        a1_q.push_back(a1);
                        if (c == "A" || c == "P" || c == "D") begin
                            total += a0;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = 10 * total + 500;
    endtask

    task automatic run_commands();
        logic [`AXI_DW-1:0] rd;
        logic [`AXI_DW-1:0] last_rd;
        last_rd = '0;
        for (int i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                "W": axi_write(a0_q[i], a1_q[i]);
                "R": begin
                    axi_read(a0_q[i], rd);
                    assert (rd == a1_q[i]) else begin
                        data_errs++;
                        $display("Error at %0t: s_rdata_o at address %0h expected %0h, got %0h",
                                 $time, a0_q[i], a1_q[i], rd);
                    end
                    last_rd = rd;
                end
                "N": begin
                    axi_read(a0_q[i], rd);
                    assert (rd != 0) else begin
                        data_errs++;
                        $display("Error at %0t: s_rdata_o at address %0h expected non-zero, got %0h",
                                 $time, a0_q[i], rd);
                    end
                    last_rd = rd;
                end
                "S": begin
                    axi_read(a0_q[i], rd);
                    assert (rd == last_rd) else begin
                        data_errs++;
                        $display("Error at %0t: s_rdata_o at address %0h expected %0h, got %0h",
                                 $time, a0_q[i], last_rd, rd);
                    end
                    last_rd = rd;
                end
                "A": begin
                    repeat (a0_q[i]) drive_word(a1_q[i]);
                    end_words();
                end
                "P": send_prbs(a0_q[i], a1_q[i]);
                "D": repeat (a0_q[i]) @(posedge clk_adc);
                default: begin
                    cmd_errs++;
                    $display("unknown command '%c' on entry %0d of the input file", cmd_q[i], i);
                end
            endcase
        end
    endtask

    initial begin
        cdr_rstb    = 1'b0;
        adc_valid_i = 1'b0;
        for (int k = 0; k < `NTI; k++) begin
            adc_code_i[k] = '0;
        end
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        load_commands();
        if (!file_ok) begin
            $display("could not open verif/rx_dcore_input.txt");
        end
        repeat (4) @(posedge clk_adc);
        cdr_rstb <= 1'b1;
        if (file_ok) begin
            run_commands();
        end
        repeat (5) @(posedge clk_adc);
        $display("errors: %0d data, %0d response, %0d command, %0d assertion",
                 data_errs, resp_errs, cmd_errs, u_dut.u_assert.fail_cnt);
        if (file_ok && data_errs == 0 && resp_errs == 0 && cmd_errs == 0
                && u_dut.u_assert.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
